//--- vlog.f
source/raster_pkg.sv
source/raster_input_stage.sv
source/line_setup.sv
source/line_fifo.sv
source/line_generator.sv
source/rasterizer_top.sv
test/rasterizer_tb.sv

//--- Bender.yml
package:
  name: rasterizer

sources:
  - files:
      - source/raster_pkg.sv
      - source/raster_input_stage.sv
      - source/line_setup.sv
      - source/line_fifo.sv
      - source/line_generator.sv
      - source/rasterizer_top.sv
  - target: test
    files:
      - test/rasterizer_tb.sv

//--- test/rasterizer_tb.sv
`default_nettype none

module rasterizer_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import raster_pkg::*;

	localparam int FIFO_DEPTH = 8;
	localparam int TIMEOUT    = 20000;

	// frame_ready drive modes
	localparam int READY_HIGH   = 0;
	localparam int READY_RANDOM = 1;
	localparam int READY_LOW    = 2;

	logic     clk;
	logic     rst;
	logic     valid;
	logic     end_of_objects;
	logic     frame_start;
	logic     frame_ready;
	coord_x_t x0;
	coord_x_t x1;
	coord_y_t y0;
	coord_y_t y1;
	color_t   color;
	logic     raster_ready;
	logic     px_valid;
	logic     raster_done;
	coord_x_t frame_x;
	coord_y_t frame_y;
	color_t   px_color;

	// Expected pixel stream and completion count
	coord_x_t exp_x[$];
	coord_y_t exp_y[$];
	color_t   exp_c[$];
	int       done_pending;
	int       ready_mode;
	string    test_name;

	// Pixel held across a stalled cycle
	logic     held;
	coord_x_t held_x;
	coord_y_t held_y;
	color_t   held_c;
	logic     done_ok;

	rasterizer_top #(.FIFO_DEPTH(FIFO_DEPTH)) rasterizer_top_i
	(
		.clk            (clk),
		.rst            (rst),
		.valid          (valid),
		.end_of_objects (end_of_objects),
		.frame_start    (frame_start),
		.x0             (x0),
		.y0             (y0),
		.x1             (x1),
		.y1             (y1),
		.color          (color),
		.frame_ready    (frame_ready),
		.raster_ready   (raster_ready),
		.px_valid       (px_valid),
		.frame_x        (frame_x),
		.frame_y        (frame_y),
		.px_color       (px_color),
		.raster_done    (raster_done)
	);

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic fail_with(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		abort_run();
	endtask

	task automatic check_x(input string name, input coord_x_t expected, input coord_x_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: frame_x expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_y(input string name, input coord_y_t expected, input coord_y_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: frame_y expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_color(input string name, input color_t expected, input color_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: px_color expected %0d, actual %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_done(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: raster_done expected %b, actual %b", name, expected, actual);
			abort_run();
		end
	endtask

	// Bresenham reference, run on each line when it is sent
	function automatic void model_line(input int ax0, input int ay0, input int ax1,
		input int ay1, input int c);
		int dx;
		int dy;
		int steep;
		int m0;
		int m1;
		int n0;
		int n1;
		int tmp;
		int dmaj;
		int dmin;
		int err;
		int mn;
		dx = (ax1 >= ax0) ? ax1 - ax0 : ax0 - ax1;
		dy = (ay1 >= ay0) ? ay1 - ay0 : ay0 - ay1;
		steep = (dy > dx);
		m0 = steep ? ay0 : ax0;
		m1 = steep ? ay1 : ax1;
		n0 = steep ? ax0 : ay0;
		n1 = steep ? ax1 : ay1;
		if (m0 > m1)
		begin
			tmp = m0;
			m0 = m1;
			m1 = tmp;
			tmp = n0;
			n0 = n1;
			n1 = tmp;
		end
		dmaj = m1 - m0;
		dmin = (n1 >= n0) ? n1 - n0 : n0 - n1;
		err = dmaj / 2;
		mn = n0;
		for (int m = m0; m <= m1; m++)
		begin
			exp_x.push_back(coord_x_t'(steep ? mn : m));
			exp_y.push_back(coord_y_t'(steep ? m : mn));
			exp_c.push_back(color_t'(c));
			err = err - dmin;
			if (err < 0)
			begin
				mn = (n1 < n0) ? mn - 1 : mn + 1;
				err = err + dmaj;
			end
		end
	endfunction

	// One cycle: strobes drop, frame_ready follows the current mode
	task automatic step();
		@(negedge clk);
		valid = 1'b0;
		end_of_objects = 1'b0;
		frame_start = 1'b0;
		case (ready_mode)
			READY_HIGH:   frame_ready = 1'b1;
			READY_RANDOM: frame_ready = $urandom_range(0, 1);
			default:      frame_ready = 1'b0;
		endcase
	endtask

	task automatic drive_line(input int ax0, input int ay0, input int ax1, input int ay1,
		input int c);
		valid = 1'b1;
		x0 = coord_x_t'(ax0);
		y0 = coord_y_t'(ay0);
		x1 = coord_x_t'(ax1);
		y1 = coord_y_t'(ay1);
		color = color_t'(c);
		model_line(ax0, ay0, ax1, ay1, c);
	endtask

	task automatic send_line(input int ax0, input int ay0, input int ax1, input int ay1,
		input int c);
		int n = 0;
		step();
		while (!raster_ready)
		begin
			if (n == TIMEOUT)
				fail_with("raster_ready stayed low");
			n++;
			step();
		end
		drive_line(ax0, ay0, ax1, ay1, c);
	endtask

	// Short line of any octant inside a small window
	task automatic pick_line(output int ax0, output int ay0, output int ax1, output int ay1,
		output int c);
		int bx;
		int by;
		bx = $urandom_range(0, 600);
		by = $urandom_range(0, 440);
		ax0 = bx + $urandom_range(0, 39);
		ax1 = bx + $urandom_range(0, 39);
		ay0 = by + $urandom_range(0, 39);
		ay1 = by + $urandom_range(0, 39);
		c = $urandom_range(0, 7);
	endtask

	task automatic send_random_lines(input int count);
		int ax0;
		int ay0;
		int ax1;
		int ay1;
		int c;
		for (int i = 0; i < count; i++)
		begin
			pick_line(ax0, ay0, ax1, ay1, c);
			send_line(ax0, ay0, ax1, ay1, c);
		end
	endtask

	task automatic wait_drain();
		int n = 0;
		step();
		while (exp_x.size() != 0 || px_valid)
		begin
			if (n == TIMEOUT)
				fail_with("expected pixels never arrived");
			n++;
			step();
		end
	endtask

	task automatic wait_done();
		int n = 0;
		step();
		while (done_pending != 0)
		begin
			if (n == TIMEOUT)
				fail_with("raster_done never pulsed after end_of_objects");
			n++;
			step();
		end
	endtask

	// Fill the FIFO with frame_ready low until raster_ready drops
	task automatic fill_burst();
		int ax0;
		int ay0;
		int ax1;
		int ay1;
		int c;
		int sent = 0;
		ready_mode = READY_LOW;
		step();
		while (raster_ready)
		begin
			if (sent == 3 * FIFO_DEPTH)
				fail_with("raster_ready never dropped during a burst");
			pick_line(ax0, ay0, ax1, ay1, c);
			drive_line(ax0, ay0, ax1, ay1, c);
			sent++;
			step();
		end
		// Let in-flight lines land while still stalled
		repeat (6) step();
		ready_mode = READY_RANDOM;
		wait_drain();
	endtask

	task automatic mark_end();
		step();
		end_of_objects = 1'b1;
		done_pending++;
		wait_done();
		repeat (20) step();
	endtask

	// Pixel, hold and completion monitor
	always @(posedge clk)
	begin
		if (rst)
		begin
			if (held)
			begin
				if (!px_valid)
					fail_with("px_valid dropped while frame_ready was low");
				check_x({test_name, " hold"}, held_x, frame_x);
				check_y({test_name, " hold"}, held_y, frame_y);
				check_color({test_name, " hold"}, held_c, px_color);
			end
			if (px_valid && frame_ready)
			begin
				if (exp_x.size() == 0)
					fail_with("pixel accepted while none was expected");
				check_x(test_name, exp_x[0], frame_x);
				check_y(test_name, exp_y[0], frame_y);
				check_color(test_name, exp_c[0], px_color);
				void'(exp_x.pop_front());
				void'(exp_y.pop_front());
				void'(exp_c.pop_front());
			end
			held = px_valid && !frame_ready;
			held_x = frame_x;
			held_y = frame_y;
			held_c = px_color;
			if (raster_done)
			begin
				done_ok = (done_pending > 0) && (exp_x.size() == 0);
				check_done(test_name, done_ok, raster_done);
				done_pending--;
			end
		end
	end

	initial
	begin
		void'($urandom(32'h917e));
		clk = 1'b0;
		rst = 1'b0;
		valid = 1'b0;
		end_of_objects = 1'b0;
		frame_start = 1'b0;
		frame_ready = 1'b1;
		x0 = '0;
		x1 = '0;
		y0 = '0;
		y1 = '0;
		color = '0;
		held = 1'b0;
		done_pending = 0;
		ready_mode = READY_HIGH;
		test_name = "reset";

		repeat (4) @(negedge clk);
		rst = 1'b1;
		step();
		if (px_valid !== 1'b0 || raster_ready !== 1'b1)
			fail_with("px_valid or raster_ready wrong after reset");
		check_done(test_name, 1'b0, raster_done);

		test_name = "octants";
		send_random_lines(40);
		wait_drain();

		test_name = "directed";
		send_line(100, 50, 60, 40, 1);
		send_line(30, 200, 20, 150, 2);
		send_line(321, 123, 321, 123, 3);
		send_line(10, 10, 40, 10, 4);
		send_line(40, 20, 10, 20, 5);
		send_line(500, 0, 500, 30, 6);
		send_line(501, 30, 501, 0, 7);
		send_line(0, 0, 20, 20, 0);
		send_line(20, 0, 0, 20, 1);
		send_line(0, 0, 639, 479, 2);
		send_line(12, 479, 5, 0, 3);
		wait_drain();

		test_name = "stall";
		ready_mode = READY_RANDOM;
		send_random_lines(40);
		wait_drain();

		test_name = "burst";
		repeat (4) fill_burst();

		test_name = "done";
		send_random_lines(10);
		mark_end();
		step();
		frame_start = 1'b1;
		send_random_lines(12);
		mark_end();
		wait_drain();

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/rasterizer_top.sv
`default_nettype none

module rasterizer_top
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  logic                clk,
	input  logic                rst,
	input  logic                valid,
	input  logic                end_of_objects,
	input  logic                frame_start,
	input  raster_pkg::coord_x_t x0,
	input  raster_pkg::coord_y_t y0,
	input  raster_pkg::coord_x_t x1,
	input  raster_pkg::coord_y_t y1,
	input  raster_pkg::color_t   color,
	input  logic                frame_ready,
	output logic                raster_ready,
	output logic                px_valid,
	output raster_pkg::coord_x_t frame_x,
	output raster_pkg::coord_y_t frame_y,
	output raster_pkg::color_t   px_color,
	output logic                raster_done
);

	import raster_pkg::*;

	// Input stage to setup
	logic     line_strobe;
	logic     eoo_strobe;
	coord_x_t cap_x0;
	coord_x_t cap_x1;
	coord_y_t cap_y0;
	coord_y_t cap_y1;
	color_t   cap_color;

	// Setup to FIFO
	logic     push;
	logic     end_mark;
	coord_x_t p0;
	coord_x_t p1;
	coord_x_t s0;
	delta_t   d_major;
	delta_t   d_minor;
	logic     minor_dec;
	logic     steep;
	color_t   line_color;

	// FIFO head to generator
	coord_x_t head_p0;
	coord_x_t head_p1;
	coord_x_t head_s0;
	delta_t   head_d_major;
	delta_t   head_d_minor;
	logic     head_minor_dec;
	logic     head_steep;
	color_t   head_line_color;
	logic     empty;
	logic     pop;

	raster_input_stage u_input_stage
	(
		.clk            (clk),
		.rst            (rst),
		.valid          (valid),
		.end_of_objects (end_of_objects),
		.x0             (x0),
		.x1             (x1),
		.y0             (y0),
		.y1             (y1),
		.color          (color),
		.line_strobe    (line_strobe),
		.eoo_strobe     (eoo_strobe),
		.cap_x0         (cap_x0),
		.cap_x1         (cap_x1),
		.cap_y0         (cap_y0),
		.cap_y1         (cap_y1),
		.cap_color      (cap_color)
	);

	line_setup u_setup
	(
		.clk         (clk),
		.rst         (rst),
		.line_strobe (line_strobe),
		.eoo_strobe  (eoo_strobe),
		.cap_x0      (cap_x0),
		.cap_x1      (cap_x1),
		.cap_y0      (cap_y0),
		.cap_y1      (cap_y1),
		.cap_color   (cap_color),
		.push        (push),
		.end_mark    (end_mark),
		.p0          (p0),
		.p1          (p1),
		.s0          (s0),
		.d_major     (d_major),
		.d_minor     (d_minor),
		.minor_dec   (minor_dec),
		.steep       (steep),
		.line_color  (line_color)
	);

	line_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
	(
		.clk             (clk),
		.rst             (rst),
		.push            (push),
		.p0              (p0),
		.p1              (p1),
		.s0              (s0),
		.d_major         (d_major),
		.d_minor         (d_minor),
		.minor_dec       (minor_dec),
		.steep           (steep),
		.line_color      (line_color),
		.pop             (pop),
		.head_p0         (head_p0),
		.head_p1         (head_p1),
		.head_s0         (head_s0),
		.head_d_major    (head_d_major),
		.head_d_minor    (head_d_minor),
		.head_minor_dec  (head_minor_dec),
		.head_steep      (head_steep),
		.head_line_color (head_line_color),
		.empty           (empty),
		.ready           (raster_ready)
	);

	line_generator u_generator
	(
		.clk             (clk),
		.rst             (rst),
		.empty           (empty),
		.head_p0         (head_p0),
		.head_p1         (head_p1),
		.head_s0         (head_s0),
		.head_d_major    (head_d_major),
		.head_d_minor    (head_d_minor),
		.head_minor_dec  (head_minor_dec),
		.head_steep      (head_steep),
		.head_line_color (head_line_color),
		.pop             (pop),
		.end_mark        (end_mark),
		.frame_start     (frame_start),
		.frame_ready     (frame_ready),
		.px_valid        (px_valid),
		.raster_done     (raster_done),
		.frame_x         (frame_x),
		.frame_y         (frame_y),
		.px_color        (px_color)
	);

endmodule

`default_nettype wire

//--- source/line_generator.sv
`default_nettype none

module line_generator
(
	input  logic                clk,
	input  logic                rst,
	input  logic                empty,
	input  raster_pkg::coord_x_t head_p0,
	input  raster_pkg::coord_x_t head_p1,
	input  raster_pkg::coord_x_t head_s0,
	input  raster_pkg::delta_t   head_d_major,
	input  raster_pkg::delta_t   head_d_minor,
	input  logic                head_minor_dec,
	input  logic                head_steep,
	input  raster_pkg::color_t   head_line_color,
	output logic                pop,
	input  logic                end_mark,
	input  logic                frame_start,
	input  logic                frame_ready,
	output logic                px_valid,
	output logic                raster_done,
	output raster_pkg::coord_x_t frame_x,
	output raster_pkg::coord_y_t frame_y,
	output raster_pkg::color_t   px_color
);

	import raster_pkg::*;

	gen_state_t state;

	// Current line
	coord_x_t maj;
	coord_x_t min;
	coord_x_t maj_end;
	delta_t   d_major;
	delta_t   d_minor;
	logic     minor_dec;
	logic     steep;
	color_t   color;

	// Error term, one bit of headroom on each side of delta_t
	logic signed [11:0] err;
	logic signed [11:0] err_next;

	logic accept;
	logic last_px;
	logic end_flag;
	logic done_cond;

	assign accept  = px_valid && frame_ready;
	assign last_px = (maj == maj_end);

	// Pop from idle, or straight from the last pixel of the previous line
	assign pop = !empty && ((state == GEN_IDLE) ||
		(state == GEN_STEP && accept && last_px));

	assign err_next = err - $signed({2'b00, d_minor});

	// Map major and minor back to frame axes
	assign frame_x  = steep ? min : maj;
	assign frame_y  = steep ? coord_y_t'(maj) : coord_y_t'(min);
	assign px_color = color;

	assign done_cond = end_flag && empty && (state == GEN_IDLE) && !px_valid;

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			state    <= GEN_IDLE;
			px_valid <= 1'b0;
		end
		else
		begin
			case (state)
				GEN_IDLE:
				begin
					if (pop)
						state <= GEN_LOAD;
				end
				GEN_LOAD:
				begin
					px_valid <= 1'b1;
					state    <= GEN_STEP;
				end
				GEN_STEP:
				begin
					if (accept && last_px)
					begin
						px_valid <= 1'b0;
						state    <= pop ? GEN_LOAD : GEN_IDLE;
					end
				end
				default:
				begin
					px_valid <= 1'b0;
					state    <= GEN_IDLE;
				end
			endcase
		end
	end

	// Line datapath and Bresenham stepping
	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			maj       <= head_p0;
			maj_end   <= head_p1;
			min       <= head_s0;
			d_major   <= head_d_major;
			d_minor   <= head_d_minor;
			minor_dec <= head_minor_dec;
			steep     <= head_steep;
			color     <= head_line_color;
		end
		else if (state == GEN_LOAD)
		begin
			err <= $signed({3'b000, d_major[9:1]});
		end
		else if (state == GEN_STEP && accept && !last_px)
		begin
			maj <= maj + 1'b1;
			if (err_next < 0)
			begin
				min <= minor_dec ? min - 1'b1 : min + 1'b1;
				err <= err_next + $signed({2'b00, d_major});
			end
			else
			begin
				err <= err_next;
			end
		end
	end

	// Sticky end of objects and the completion pulse
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			end_flag    <= 1'b0;
			raster_done <= 1'b0;
		end
		else
		begin
			raster_done <= done_cond;
			if (frame_start)
				end_flag <= 1'b0;
			else if (end_mark)
				end_flag <= 1'b1;
			else if (done_cond)
				end_flag <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/line_fifo.sv
`default_nettype none

module line_fifo
#(
	parameter int FIFO_DEPTH = 8
)
(
	input  logic                clk,
	input  logic                rst,
	input  logic                push,
	input  raster_pkg::coord_x_t p0,
	input  raster_pkg::coord_x_t p1,
	input  raster_pkg::coord_x_t s0,
	input  raster_pkg::delta_t   d_major,
	input  raster_pkg::delta_t   d_minor,
	input  logic                minor_dec,
	input  logic                steep,
	input  raster_pkg::color_t   line_color,
	input  logic                pop,
	output raster_pkg::coord_x_t head_p0,
	output raster_pkg::coord_x_t head_p1,
	output raster_pkg::coord_x_t head_s0,
	output raster_pkg::delta_t   head_d_major,
	output raster_pkg::delta_t   head_d_minor,
	output logic                head_minor_dec,
	output logic                head_steep,
	output raster_pkg::color_t   head_line_color,
	output logic                empty,
	output logic                ready
);

	import raster_pkg::*;

	localparam int ENTRY_W = 3 * $bits(coord_x_t) + 2 * $bits(delta_t) + 2 + $bits(color_t);
	localparam int PTR_W   = $clog2(FIFO_DEPTH);
	localparam int CNT_W   = $clog2(FIFO_DEPTH + 1);

	logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               wr_en;
	logic               rd_en;

	assign wr_en = push && (count != CNT_W'(FIFO_DEPTH));
	assign rd_en = pop && !empty;

	assign empty = (count == '0);
	// Room kept for the two lines still in the input and setup stages
	assign ready = (count <= CNT_W'(FIFO_DEPTH - 3));

	// Head entry falls through to the outputs
	assign {head_p0, head_p1, head_s0, head_d_major, head_d_minor,
		head_minor_dec, head_steep, head_line_color} = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= {p0, p1, s0, d_major, d_minor, minor_dec, steep, line_color};
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// Pointers wrap at FIFO_DEPTH, not at a power of two
			if (wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/line_setup.sv
`default_nettype none

module line_setup
(
	input  logic                clk,
	input  logic                rst,
	input  logic                line_strobe,
	input  logic                eoo_strobe,
	input  raster_pkg::coord_x_t cap_x0,
	input  raster_pkg::coord_x_t cap_x1,
	input  raster_pkg::coord_y_t cap_y0,
	input  raster_pkg::coord_y_t cap_y1,
	input  raster_pkg::color_t   cap_color,
	output logic                push,
	output logic                end_mark,
	output raster_pkg::coord_x_t p0,
	output raster_pkg::coord_x_t p1,
	output raster_pkg::coord_x_t s0,
	output raster_pkg::delta_t   d_major,
	output raster_pkg::delta_t   d_minor,
	output logic                minor_dec,
	output logic                steep,
	output raster_pkg::color_t   line_color
);

	import raster_pkg::*;

	coord_x_t y0_ext;
	coord_x_t y1_ext;
	delta_t   dx;
	delta_t   dy;
	logic     steep_c;
	coord_x_t maj0;
	coord_x_t maj1;
	coord_x_t min0;
	coord_x_t min1;
	logic     swap;

	// y widened so both axes share one datapath
	assign y0_ext = coord_x_t'(cap_y0);
	assign y1_ext = coord_x_t'(cap_y1);

	assign dx = (cap_x1 >= cap_x0) ? cap_x1 - cap_x0 : cap_x0 - cap_x1;
	assign dy = (y1_ext >= y0_ext) ? y1_ext - y0_ext : y0_ext - y1_ext;

	// Steep lines step along y
	assign steep_c = (dy > dx);

	assign maj0 = steep_c ? y0_ext : cap_x0;
	assign maj1 = steep_c ? y1_ext : cap_x1;
	assign min0 = steep_c ? cap_x0 : y0_ext;
	assign min1 = steep_c ? cap_x1 : y1_ext;

	// Draw from the lower major coordinate
	assign swap = (maj0 > maj1);

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			push     <= 1'b0;
			end_mark <= 1'b0;
		end
		else
		begin
			push     <= line_strobe;
			end_mark <= eoo_strobe;
		end
	end

	// Ordered line fields, valid alongside push
	always_ff @(posedge clk)
	begin
		if (line_strobe)
		begin
			p0         <= swap ? maj1 : maj0;
			p1         <= swap ? maj0 : maj1;
			s0         <= swap ? min1 : min0;
			minor_dec  <= swap ? (min0 < min1) : (min1 < min0);
			d_major    <= steep_c ? dy : dx;
			d_minor    <= steep_c ? dx : dy;
			steep      <= steep_c;
			line_color <= cap_color;
		end
	end

endmodule

`default_nettype wire

//--- source/raster_input_stage.sv
`default_nettype none

module raster_input_stage
(
	input  logic                clk,
	input  logic                rst,
	input  logic                valid,
	input  logic                end_of_objects,
	input  raster_pkg::coord_x_t x0,
	input  raster_pkg::coord_x_t x1,
	input  raster_pkg::coord_y_t y0,
	input  raster_pkg::coord_y_t y1,
	input  raster_pkg::color_t   color,
	output logic                line_strobe,
	output logic                eoo_strobe,
	output raster_pkg::coord_x_t cap_x0,
	output raster_pkg::coord_x_t cap_x1,
	output raster_pkg::coord_y_t cap_y0,
	output raster_pkg::coord_y_t cap_y1,
	output raster_pkg::color_t   cap_color
);

	import raster_pkg::*;

	// Strobes are delayed one cycle to line up with the captured fields
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			line_strobe <= 1'b0;
			eoo_strobe  <= 1'b0;
		end
		else
		begin
			line_strobe <= valid;
			eoo_strobe  <= end_of_objects;
		end
	end

	// Endpoint capture, held until the next valid
	always_ff @(posedge clk)
	begin
		if (valid)
		begin
			cap_x0    <= x0;
			cap_x1    <= x1;
			cap_y0    <= y0;
			cap_y1    <= y1;
			cap_color <= color;
		end
	end

endmodule

`default_nettype wire

//--- source/raster_pkg.sv
`default_nettype none

package raster_pkg;

	// Frame coordinates, 640x480 class frame
	typedef logic [9:0] coord_x_t;
	typedef logic [8:0] coord_y_t;

	// Pixel color index
	typedef logic [2:0] color_t;

	// Absolute coordinate difference, wide enough for either axis
	typedef logic [9:0] delta_t;

	// Line generator FSM
	typedef enum logic [1:0]
	{
		GEN_IDLE,
		GEN_LOAD,
		GEN_STEP
	} gen_state_t;

endpackage

`default_nettype wire
